// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ccip_std_afu
FILELIST  ?= list.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := All checks passed

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/afu_asserts.sv ====
module afu_asserts
    import ccip_pkg::*;
(
    input logic        pClk,
    input logic        rst_n,
    input logic        start,
    input logic        busy,
    input logic        done,
    input logic        host_rsp_valid,
    input logic        c0_tx_valid,
    input t_ccip_mdata c0_tx_mdata
);

    // **********************************************************
    // Job control between register file and engine
    // **********************************************************

    // Start never hits a running job
    start_not_busy: assert property (@(posedge pClk) disable iff (!rst_n)
        start |-> !busy)
        else $error("Start pulse while the engine is busy");

    // Single pulse, and the engine picks the job up
    start_taken: assert property (@(posedge pClk) disable iff (!rst_n)
        start |=> !start && (busy || done))
        else $error("Start pulse too long or job not taken");

    // Done stays until the next start
    done_held: assert property (@(posedge pClk) disable iff (!rst_n)
        done && !start |=> done)
        else $error("Done dropped without a new start");

    // Done follows a response, or a start for an empty job
    done_after_rsp: assert property (@(posedge pClk) disable iff (!rst_n)
        $rose(done) |-> $past(host_rsp_valid) || $past(start))
        else $error("Done rose without a final response");

    // **********************************************************
    // Read request channel
    // **********************************************************

    // Tags go out in order, none skipped
    tag_in_order: assert property (@(posedge pClk) disable iff (!rst_n)
        c0_tx_valid |=> c0_tx_mdata == $past(c0_tx_mdata) + 1'b1)
        else $error("Read request tag skipped or repeated");

endmodule

// Both blocks meet inside the user AFU
bind afu afu_asserts u_afu_asserts (
    .pClk           (pClk),
    .rst_n          (rst_n),
    .start          (start),
    .busy           (busy),
    .done           (done),
    .host_rsp_valid (host_rsp_valid),
    .c0_tx_valid    (c0_tx_valid),
    .c0_tx_mdata    (c0_tx_mdata)
);

// ==== bench/tb_ccip_std_afu.sv ====
module tb_ccip_std_afu
    import ccip_pkg::*, afu_csr_pkg::*;
;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_JOBS   = 5;
    // Room for the tags of one job in the hit table
    localparam int TAG_SLOTS  = 64;

    logic           pClk;
    logic           rst_n               = 1'b0;
    logic           c0_rx_rsp_valid     = 1'b0;
    logic           c0_rx_mmio_rd_valid = 1'b0;
    logic           c0_rx_mmio_wr_valid = 1'b0;
    t_ccip_mdata    c0_rx_mdata         = '0;
    t_ccip_clData   c0_rx_data          = '0;
    t_ccip_mmioAddr c0_rx_mmio_addr     = '0;
    t_ccip_tid      c0_rx_mmio_tid      = '0;
    logic           c0_tx_alm_full      = 1'b0;
    logic           c0_tx_valid;
    t_ccip_clAddr   c0_tx_addr;
    t_ccip_mdata    c0_tx_mdata;
    logic           c2_tx_mmio_rd_valid;
    t_ccip_tid      c2_tx_tid;
    t_ccip_mmioData c2_tx_data;

    // MMIO request slot from the sequence to the channel driver
    int             req_seq;
    int             ack_seq;
    bit             req_write;
    t_ccip_mmioAddr req_addr;
    t_ccip_mmioData req_data;
    t_ccip_tid      req_tid;
    // Host memory and requests still waiting for data
    t_ccip_clData   host_mem [t_ccip_clAddr];
    t_ccip_clAddr   pend_addr [$];
    t_ccip_mdata    pend_tag [$];
    // Job the sequence is running now
    int             cur_job;
    t_ccip_clAddr   cur_addr;
    int             cur_lines;
    int             req_cnt [0:NUM_JOBS-1];
    int             hits [0:NUM_JOBS*TAG_SLOTS-1];
    int             err_main;
    int             err_host;

    ccip_std_afu u_ccip_std_afu (
        .pClk                (pClk),
        .rst_n               (rst_n),
        .c0_rx_rsp_valid     (c0_rx_rsp_valid),
        .c0_rx_mmio_rd_valid (c0_rx_mmio_rd_valid),
        .c0_rx_mmio_wr_valid (c0_rx_mmio_wr_valid),
        .c0_rx_mdata         (c0_rx_mdata),
        .c0_rx_data          (c0_rx_data),
        .c0_rx_mmio_addr     (c0_rx_mmio_addr),
        .c0_rx_mmio_tid      (c0_rx_mmio_tid),
        .c0_tx_alm_full      (c0_tx_alm_full),
        .c0_tx_valid         (c0_tx_valid),
        .c0_tx_addr          (c0_tx_addr),
        .c0_tx_mdata         (c0_tx_mdata),
        .c2_tx_mmio_rd_valid (c2_tx_mmio_rd_valid),
        .c2_tx_tid           (c2_tx_tid),
        .c2_tx_data          (c2_tx_data)
    );

    initial begin
        pClk = 1'b0;
        forever #(CLK_PERIOD/2) pClk = ~pClk;
    end

    // **********************************************************
    // Host side of the channels
    // **********************************************************

    always @(posedge pClk) begin : host_side
        int idx;
        // Request seen by the DUT at this edge
        if (rst_n && c0_tx_valid) begin
            if (c0_tx_alm_full) begin
                $display("Read request issued while almost full was high at %0t", $time);
                err_host = err_host + 1;
            end
            if (int'(c0_tx_mdata) >= cur_lines
                || c0_tx_addr != cur_addr + t_ccip_clAddr'(c0_tx_mdata)) begin
                $display("Mismatch at %0t: request addr %h tag %0d outside the job",
                         $time, c0_tx_addr, c0_tx_mdata);
                err_host = err_host + 1;
            end else begin
                hits[cur_job*TAG_SLOTS + int'(c0_tx_mdata)] += 1;
            end
            req_cnt[cur_job] = req_cnt[cur_job] + 1;
            pend_addr.push_back(c0_tx_addr);
            pend_tag.push_back(c0_tx_mdata);
        end
        c0_rx_rsp_valid     <= 1'b0;
        c0_rx_mmio_rd_valid <= 1'b0;
        c0_rx_mmio_wr_valid <= 1'b0;
        c0_tx_alm_full      <= ($urandom % 4) == 0;
        // MMIO takes the channel first and strobes never overlap
        if (req_seq != ack_seq) begin
            c0_rx_mmio_rd_valid <= !req_write;
            c0_rx_mmio_wr_valid <= req_write;
            c0_rx_mmio_addr     <= req_addr;
            c0_rx_mmio_tid      <= req_tid;
            c0_rx_data          <= req_data;
            ack_seq = ack_seq + 1;
        end else if (pend_tag.size() > 0 && ($urandom % 3) == 0) begin
            // Any pending entry may come back next
            idx = $urandom % pend_tag.size();
            c0_rx_rsp_valid <= 1'b1;
            c0_rx_mdata     <= pend_tag[idx];
            c0_rx_data      <= host_mem[pend_addr[idx]];
            pend_addr.delete(idx);
            pend_tag.delete(idx);
        end
    end

    // **********************************************************
    // Sequence tasks
    // **********************************************************

    task automatic report_mismatch(input string what);
        $display("Mismatch at %0t: %s", $time, what);
        err_main = err_main + 1;
    endtask

    task automatic send_mmio(input bit is_write, input t_ccip_mmioAddr addr,
                             input t_ccip_mmioData data, input t_ccip_tid tid);
        @(negedge pClk);
        req_write = is_write;
        req_addr  = addr;
        req_data  = data;
        req_tid   = tid;
        req_seq   = req_seq + 1;
        // Returns on the edge where the strobe goes out
        wait (ack_seq == req_seq);
    endtask

    task automatic read_csr(input t_ccip_mmioAddr addr, output t_ccip_mmioData data);
        t_ccip_tid tid;
        tid = t_ccip_tid'($urandom);
        send_mmio(1'b0, addr, '0, tid);
        @(negedge pClk);
        if (c2_tx_mmio_rd_valid) begin
            report_mismatch($sformatf("read of %h answered too early", addr));
        end
        // One cycle after the DUT took the request
        @(negedge pClk);
        if (!c2_tx_mmio_rd_valid || c2_tx_tid != tid) begin
            report_mismatch($sformatf("read of %h valid %b tid %0d expected tid %0d",
                                      addr, c2_tx_mmio_rd_valid, c2_tx_tid, tid));
        end
        data = c2_tx_data;
    endtask

    task automatic run_job(input int job, input int lines, input bit restart);
        t_ccip_clAddr   base;
        t_ccip_clData   line;
        t_ccip_clData   expect_sum;
        t_ccip_mmioData rd;
        base       = t_ccip_clAddr'({$urandom, $urandom});
        expect_sum = '0;
        // Fresh memory contents and the model checksum
        for (int i = 0; i < lines; i++) begin
            line = {$urandom, $urandom};
            host_mem[base + t_ccip_clAddr'(i)] = line;
            expect_sum = expect_sum ^ line;
        end
        cur_job   = job;
        cur_addr  = base;
        cur_lines = lines;
        send_mmio(1'b1, CSR_SRC_ADDR, t_ccip_mmioData'(base), '0);
        send_mmio(1'b1, CSR_NUM_LINES, t_ccip_mmioData'(lines), '0);
        send_mmio(1'b1, CSR_CTRL, 64'h1, '0);
        // Start pulse and engine state settle first
        repeat (4) @(posedge pClk);
        if (restart) begin
            read_csr(CSR_STATUS, rd);
            if (!rd[STATUS_BUSY_BIT]) begin
                report_mismatch("engine not busy before the second start");
            end
            send_mmio(1'b1, CSR_CTRL, 64'h1, '0);
        end
        rd = '0;
        while (!rd[STATUS_DONE_BIT]) begin
            read_csr(CSR_STATUS, rd);
        end
        read_csr(CSR_CHECKSUM, rd);
        if (rd != expect_sum) begin
            report_mismatch($sformatf("job %0d checksum %h expected %h", job, rd, expect_sum));
        end
        // Quiet time to catch a second job
        repeat (10) @(posedge pClk);
        if (req_cnt[job] != lines) begin
            report_mismatch($sformatf("job %0d issued %0d reads for %0d lines",
                                      job, req_cnt[job], lines));
        end
        for (int i = 0; i < lines; i++) begin
            if (hits[job*TAG_SLOTS + i] != 1) begin
                report_mismatch($sformatf("job %0d line %0d read %0d times",
                                          job, i, hits[job*TAG_SLOTS + i]));
            end
        end
    endtask

    // **********************************************************
    // Test sequence
    // **********************************************************

    initial begin
        t_ccip_mmioData rd;
        t_ccip_mmioData val;
        int             lens [0:NUM_JOBS-1];
        int             total;
        int             limit;
        void'($urandom(32'h7021));
        // Job 1 gets a second start and job 2 is empty
        total = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            lens[j] = $urandom_range(40, 0);
        end
        lens[1] = 40;
        lens[2] = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            total = total + lens[j];
        end
        limit = (200 * total + 2000) * CLK_PERIOD;
        fork
            begin
                #(limit);
                $display("Timeout after %0d time units with the run still going", limit);
                $display("Checks failed");
                $finish;
            end
        join_none

        repeat (5) @(posedge pClk);
        rst_n <= 1'b1;
        @(posedge pClk);

        read_csr(CSR_AFU_ID, rd);
        if (rd != AFU_ID_VALUE) begin
            report_mismatch($sformatf("AFU id %h expected %h", rd, AFU_ID_VALUE));
        end
        val = {$urandom, $urandom};
        send_mmio(1'b1, CSR_SCRATCH, val, '0);
        read_csr(CSR_SCRATCH, rd);
        if (rd != val) begin
            report_mismatch($sformatf("scratch %h expected %h", rd, val));
        end

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j, lens[j], j == 1);
        end

        $display("Errors %0d sequence %0d host side %0d over %0d jobs",
                 err_main + err_host, err_main, err_host, NUM_JOBS);
        if (err_main + err_host == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rtl/ccip_pkg.sv
rtl/afu_csr_pkg.sv
rtl/afu_csr.sv
rtl/afu_read_engine.sv
rtl/afu.sv
rtl/ccip_std_afu.sv
bench/afu_asserts.sv
bench/tb_ccip_std_afu.sv

// ==== rtl/afu.sv ====
module afu
    import ccip_pkg::*, afu_csr_pkg::*;
(
    input  logic           pClk,
    input  logic           rst_n,
    // Host responses
    input  logic           host_rsp_valid,
    input  t_ccip_mdata    host_rsp_mdata,
    input  t_ccip_clData   host_rsp_data,
    // MMIO requests
    input  logic           mmio_rd_valid,
    input  logic           mmio_wr_valid,
    input  t_ccip_mmioAddr mmio_addr,
    input  t_ccip_tid      mmio_tid,
    input  t_ccip_mmioData mmio_wr_data,
    // Read requests
    input  logic           c0_tx_alm_full,
    output logic           c0_tx_valid,
    output t_ccip_clAddr   c0_tx_addr,
    output t_ccip_mdata    c0_tx_mdata,
    // MMIO read responses
    output logic           c2_tx_mmio_rd_valid,
    output t_ccip_tid      c2_tx_tid,
    output t_ccip_mmioData c2_tx_data
);

    // Job setup from the register file
    logic         start;
    t_ccip_clAddr src_addr;
    t_line_count  num_lines;
    // Job state back from the engine
    logic         busy;
    logic         done;
    t_ccip_clData checksum;

    afu_csr u_afu_csr (
        .pClk                (pClk),
        .rst_n               (rst_n),
        .mmio_rd_valid       (mmio_rd_valid),
        .mmio_wr_valid       (mmio_wr_valid),
        .mmio_addr           (mmio_addr),
        .mmio_tid            (mmio_tid),
        .mmio_wr_data        (mmio_wr_data),
        .busy                (busy),
        .done                (done),
        .checksum            (checksum),
        .start               (start),
        .src_addr            (src_addr),
        .num_lines           (num_lines),
        .c2_tx_mmio_rd_valid (c2_tx_mmio_rd_valid),
        .c2_tx_tid           (c2_tx_tid),
        .c2_tx_data          (c2_tx_data)
    );

    afu_read_engine u_afu_read_engine (
        .pClk           (pClk),
        .rst_n          (rst_n),
        .start          (start),
        .src_addr       (src_addr),
        .num_lines      (num_lines),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp_mdata (host_rsp_mdata),
        .host_rsp_data  (host_rsp_data),
        .c0_tx_alm_full (c0_tx_alm_full),
        .c0_tx_valid    (c0_tx_valid),
        .c0_tx_addr     (c0_tx_addr),
        .c0_tx_mdata    (c0_tx_mdata),
        .busy           (busy),
        .done           (done),
        .checksum       (checksum)
    );

endmodule

// ==== rtl/afu_csr.sv ====
module afu_csr
    import ccip_pkg::*, afu_csr_pkg::*;
(
    input  logic           pClk,
    input  logic           rst_n,
    input  logic           mmio_rd_valid,
    input  logic           mmio_wr_valid,
    input  t_ccip_mmioAddr mmio_addr,
    input  t_ccip_tid      mmio_tid,
    input  t_ccip_mmioData mmio_wr_data,
    // Engine status
    input  logic           busy,
    input  logic           done,
    input  t_ccip_clData   checksum,
    // Job setup
    output logic           start,
    output t_ccip_clAddr   src_addr,
    output t_line_count    num_lines,
    // Channel 2 read response
    output logic           c2_tx_mmio_rd_valid,
    output t_ccip_tid      c2_tx_tid,
    output t_ccip_mmioData c2_tx_data
);

    t_ccip_mmioData scratch;
    t_ccip_mmioData rd_data;
    logic           ctrl_start_wr;

    // Control write asking for a new job
    assign ctrl_start_wr = mmio_wr_valid && (mmio_addr == CSR_CTRL)
                           && mmio_wr_data[CTRL_START_BIT];

    // **********************************************************
    // Write decode
    // **********************************************************

    always_ff @(posedge pClk or negedge rst_n) begin
        if (!rst_n) begin
            scratch   <= '0;
            src_addr  <= '0;
            num_lines <= '0;
            start     <= 1'b0;
        end else begin
            // Pulse for one cycle only
            // Busy lags start by a cycle, so a pending pulse also blocks
            start <= ctrl_start_wr && !busy && !start;
            if (mmio_wr_valid) begin
                case (mmio_addr)
                    CSR_SCRATCH:   scratch   <= mmio_wr_data;
                    CSR_SRC_ADDR:  src_addr  <= mmio_wr_data[CCIP_CLADDR_WIDTH-1:0];
                    CSR_NUM_LINES: num_lines <= mmio_wr_data[LINE_COUNT_WIDTH-1:0];
                    // AFU_ID, STATUS and CHECKSUM ignore writes
                    default: ;
                endcase
            end
        end
    end

    // **********************************************************
    // Read mux and response
    // **********************************************************

    always_comb begin
        rd_data = '0;
        case (mmio_addr)
            CSR_AFU_ID:    rd_data = AFU_ID_VALUE;
            CSR_SCRATCH:   rd_data = scratch;
            CSR_SRC_ADDR:  rd_data = t_ccip_mmioData'(src_addr);
            CSR_NUM_LINES: rd_data = t_ccip_mmioData'(num_lines);
            CSR_STATUS: begin
                rd_data[STATUS_DONE_BIT] = done;
                rd_data[STATUS_BUSY_BIT] = busy;
            end
            CSR_CHECKSUM:  rd_data = checksum;
            // CTRL start bit clears itself and reads back 0
            default:       rd_data = '0;
        endcase
    end

    // Fixed one-cycle read latency
    always_ff @(posedge pClk or negedge rst_n) begin
        if (!rst_n) begin
            c2_tx_mmio_rd_valid <= 1'b0;
        end else begin
            c2_tx_mmio_rd_valid <= mmio_rd_valid;
        end
    end

    // Response payload, qualified by the valid above
    always_ff @(posedge pClk) begin
        if (mmio_rd_valid) begin
            c2_tx_tid  <= mmio_tid;
            c2_tx_data <= rd_data;
        end
    end

endmodule

// ==== rtl/afu_csr_pkg.sv ====
package afu_csr_pkg;

    import ccip_pkg::*;

    // **********************************************************
    // Register map, 64-bit registers on even word addresses
    // **********************************************************

    // Read only identifier
    localparam t_ccip_mmioAddr CSR_AFU_ID    = 16'h0002;
    localparam t_ccip_mmioAddr CSR_SCRATCH   = 16'h0020;
    localparam t_ccip_mmioAddr CSR_SRC_ADDR  = 16'h0022;
    localparam t_ccip_mmioAddr CSR_NUM_LINES = 16'h0024;
    // Write only, bit 0 kicks off a job
    localparam t_ccip_mmioAddr CSR_CTRL      = 16'h0026;
    localparam t_ccip_mmioAddr CSR_STATUS    = 16'h0028;
    localparam t_ccip_mmioAddr CSR_CHECKSUM  = 16'h002A;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_BUSY_BIT = 1;

    // Fixed identifier returned by CSR_AFU_ID
    localparam t_ccip_mmioData AFU_ID_VALUE = 64'h9d2f_41c7_6e0a_b315;

    // **********************************************************
    // Engine types
    // **********************************************************

    localparam int LINE_COUNT_WIDTH = 16;
    typedef logic [LINE_COUNT_WIDTH-1:0] t_line_count;

    // IDLE after reset, DONE after a finished job
    typedef enum logic [1:0] {IDLE, ISSUE, DRAIN, DONE} t_eng_state;

endpackage

// ==== rtl/afu_read_engine.sv ====
module afu_read_engine
    import ccip_pkg::*, afu_csr_pkg::*;
(
    input  logic         pClk,
    input  logic         rst_n,
    // Job setup
    input  logic         start,
    input  t_ccip_clAddr src_addr,
    input  t_line_count  num_lines,
    // Host responses, any order
    input  logic         host_rsp_valid,
    input  t_ccip_mdata  host_rsp_mdata,
    input  t_ccip_clData host_rsp_data,
    // Read request channel
    input  logic         c0_tx_alm_full,
    output logic         c0_tx_valid,
    output t_ccip_clAddr c0_tx_addr,
    output t_ccip_mdata  c0_tx_mdata,
    // Job status
    output logic         busy,
    output logic         done,
    output t_ccip_clData checksum
);

    t_eng_state   state;
    // Copy of the job setup taken at start
    t_ccip_clAddr job_addr;
    t_line_count  job_lines;
    // Issue and response sides advance on their own
    t_line_count  issue_cnt;
    t_line_count  rsp_cnt;
    logic         issue_fire;
    logic         rsp_fire;

    // **********************************************************
    // Request and status outputs
    // **********************************************************

    assign busy = (state == ISSUE) || (state == DRAIN);
    assign done = (state == DONE);

    // One request per cycle, held off while almost full
    assign c0_tx_valid = (state == ISSUE) && !c0_tx_alm_full;
    assign c0_tx_addr  = job_addr + t_ccip_clAddr'(issue_cnt);
    // Tag is the line index within the job
    assign c0_tx_mdata = t_ccip_mdata'(issue_cnt);
    assign issue_fire  = c0_tx_valid;

    // Only tags that belong to the running job count
    assign rsp_fire = host_rsp_valid && busy
                      && (t_line_count'(host_rsp_mdata) < job_lines);

    // **********************************************************
    // Engine FSM, counters and checksum
    // **********************************************************

    always_ff @(posedge pClk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            job_addr  <= '0;
            job_lines <= '0;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
            checksum  <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        job_addr  <= src_addr;
                        job_lines <= num_lines;
                        issue_cnt <= '0;
                        rsp_cnt   <= '0;
                        checksum  <= '0;
                        // Empty job finishes at once
                        state     <= (num_lines == '0) ? DONE : ISSUE;
                    end
                end
                ISSUE: begin
                    if (issue_fire) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        // Last request out, wait for the rest of the data
                        if (issue_cnt == job_lines - 1'b1) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    // Final response seen, done shows next cycle
                    if (rsp_fire && (rsp_cnt == job_lines - 1'b1)) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase

            // XOR fold makes the result order independent
            if (rsp_fire) begin
                rsp_cnt  <= rsp_cnt + 1'b1;
                checksum <= checksum ^ host_rsp_data;
            end
        end
    end

endmodule

// ==== rtl/ccip_pkg.sv ====
package ccip_pkg;

    // **********************************************************
    // Simplified CCI-P channel fields
    // **********************************************************

    // Line address in 64-byte units, as seen by the host
    localparam int CCIP_CLADDR_WIDTH   = 42;

    // Line data narrowed to a single 64-bit word
    localparam int CCIP_CLDATA_WIDTH   = 64;

    // Request tag, returned unchanged with the response
    localparam int CCIP_MDATA_WIDTH    = 16;

    // MMIO address counts 32-bit words
    localparam int CCIP_MMIOADDR_WIDTH = 16;
    localparam int CCIP_MMIODATA_WIDTH = 64;

    // MMIO transaction id, copied into the read response
    localparam int CCIP_TID_WIDTH      = 9;

    // **********************************************************
    // Field types
    // **********************************************************

    typedef logic [CCIP_CLADDR_WIDTH-1:0]   t_ccip_clAddr;
    typedef logic [CCIP_CLDATA_WIDTH-1:0]   t_ccip_clData;
    typedef logic [CCIP_MDATA_WIDTH-1:0]    t_ccip_mdata;
    typedef logic [CCIP_MMIOADDR_WIDTH-1:0] t_ccip_mmioAddr;
    typedef logic [CCIP_MMIODATA_WIDTH-1:0] t_ccip_mmioData;
    typedef logic [CCIP_TID_WIDTH-1:0]      t_ccip_tid;

endpackage

// ==== rtl/ccip_std_afu.sv ====
module ccip_std_afu
    import ccip_pkg::*;
(
    input  logic           pClk,
    input  logic           rst_n,
    // Receive channel 0, shared by host responses and MMIO
    input  logic           c0_rx_rsp_valid,
    input  logic           c0_rx_mmio_rd_valid,
    input  logic           c0_rx_mmio_wr_valid,
    input  t_ccip_mdata    c0_rx_mdata,
    input  t_ccip_clData   c0_rx_data,
    input  t_ccip_mmioAddr c0_rx_mmio_addr,
    input  t_ccip_tid      c0_rx_mmio_tid,
    // Transmit channel 0, read requests
    input  logic           c0_tx_alm_full,
    output logic           c0_tx_valid,
    output t_ccip_clAddr   c0_tx_addr,
    output t_ccip_mdata    c0_tx_mdata,
    // Transmit channel 2, MMIO read responses
    output logic           c2_tx_mmio_rd_valid,
    output t_ccip_tid      c2_tx_tid,
    output t_ccip_mmioData c2_tx_data
);

    // Host path
    logic           host_rsp_valid;
    t_ccip_mdata    host_rsp_mdata;
    t_ccip_clData   host_rsp_data;
    // MMIO path
    logic           mmio_rd_valid;
    logic           mmio_wr_valid;
    t_ccip_mmioAddr mmio_addr;
    t_ccip_tid      mmio_tid;
    t_ccip_mmioData mmio_wr_data;

    // **********************************************************
    // Split of receive channel 0
    // **********************************************************

    always_comb begin
        // Response strobe only reaches the host path
        // A cycle carrying an MMIO header is never a response
        host_rsp_valid = c0_rx_rsp_valid && !c0_rx_mmio_rd_valid && !c0_rx_mmio_wr_valid;
        host_rsp_mdata = c0_rx_mdata;
        host_rsp_data  = c0_rx_data;
        // MMIO strobes only reach the register file
        mmio_rd_valid  = c0_rx_mmio_rd_valid && !c0_rx_rsp_valid;
        mmio_wr_valid  = c0_rx_mmio_wr_valid && !c0_rx_rsp_valid;
        mmio_addr      = c0_rx_mmio_addr;
        mmio_tid       = c0_rx_mmio_tid;
        // Write data shares the line data field
        mmio_wr_data   = c0_rx_data;
    end

    // User AFU
    afu afu_inst (
        .pClk                (pClk),
        .rst_n               (rst_n),
        .host_rsp_valid      (host_rsp_valid),
        .host_rsp_mdata      (host_rsp_mdata),
        .host_rsp_data       (host_rsp_data),
        .mmio_rd_valid       (mmio_rd_valid),
        .mmio_wr_valid       (mmio_wr_valid),
        .mmio_addr           (mmio_addr),
        .mmio_tid            (mmio_tid),
        .mmio_wr_data        (mmio_wr_data),
        .c0_tx_alm_full      (c0_tx_alm_full),
        .c0_tx_valid         (c0_tx_valid),
        .c0_tx_addr          (c0_tx_addr),
        .c0_tx_mdata         (c0_tx_mdata),
        .c2_tx_mmio_rd_valid (c2_tx_mmio_rd_valid),
        .c2_tx_tid           (c2_tx_tid),
        .c2_tx_data          (c2_tx_data)
    );

endmodule
